/* compile.f */
source/cplx_pkg.sv
source/pe_isa_pkg.sv
source/pe_fetch.sv
source/pe_decode.sv
source/pe_data_mem.sv
source/pe_complex_alu.sv
source/pe_result.sv
source/pe_top.sv
dv/pe_tb.sv

/* dv/pe_tb.sv */
`timescale 1ns/1ps

module pe_tb
    import cplx_pkg::*;
    import pe_isa_pkg::*;
();

    localparam int CLK_PERIOD  = 10;
    localparam int NUM_TESTS   = 6;
    // cycle budget per test for the watchdog
    localparam int TEST_CYCLES = 400;
    // longest wait for run_ack inside one run
    localparam int RUN_LIMIT   = 300;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  inst_v;
    inst_t inst;
    logic  din_v;
    cplx_t din;
    logic  run_req;
    logic  run_ack;
    logic  dout_v;
    cplx_t dout;

    // program, data image and result queues
    inst_t prog_q [$];
    cplx_t data_init [REG_NUM];
    cplx_t model_regs [REG_NUM];
    cplx_t model_acc;
    cplx_t exp_q [$];
    cplx_t got_q [$];

    int errors;
    int tests_run;
    int tests_failed;

    always #(CLK_PERIOD / 2) clk = ~clk;

    pe_top dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .inst_v  (inst_v),
        .inst    (inst),
        .din_v   (din_v),
        .din     (din),
        .run_req (run_req),
        .run_ack (run_ack),
        .dout_v  (dout_v),
        .dout    (dout)
    );

    ////////////////////////////////////////
    // reference arithmetic
    ////////////////////////////////////////

    function automatic cplx_t make_cplx(input int re, input int im);
        cplx_t c;
        c.re = sample_t'(re);
        c.im = sample_t'(im);
        return c;
    endfunction

    // wraps modulo 2^16 per component
    function automatic cplx_t cplx_add(input cplx_t a, input cplx_t b);
        int s_re;
        int s_im;
        s_re = int'(a.re) + int'(b.re);
        s_im = int'(a.im) + int'(b.im);
        return make_cplx(s_re, s_im);
    endfunction

    function automatic cplx_t cplx_sub(input cplx_t a, input cplx_t b);
        int d_re;
        int d_im;
        d_re = int'(a.re) - int'(b.re);
        d_im = int'(a.im) - int'(b.im);
        return make_cplx(d_re, d_im);
    endfunction

    // full precision then arithmetic shift and truncate to 16 bits
    function automatic cplx_t cplx_mul(input cplx_t a, input cplx_t b);
        longint p_re;
        longint p_im;
        cplx_t  c;
        p_re = longint'(a.re) * longint'(b.re) - longint'(a.im) * longint'(b.im);
        p_im = longint'(a.re) * longint'(b.im) + longint'(a.im) * longint'(b.re);
        c.re = sample_t'(p_re >>> FRAC_BITS);
        c.im = sample_t'(p_im >>> FRAC_BITS);
        return c;
    endfunction

    // runs prog_q in order and fills exp_q
    task automatic model_program();
        inst_t w;
        cplx_t r;
        bit    writes;
        exp_q.delete();
        foreach (prog_q[i]) begin
            w = prog_q[i];
            if (w.op == OP_HALT) begin
                break;
            end
            writes = 1'b1;
            case (w.op)
                OP_ADD: r = cplx_add(model_regs[w.src_a], model_regs[w.src_b]);
                OP_SUB: r = cplx_sub(model_regs[w.src_a], model_regs[w.src_b]);
                OP_MUL: begin
                    r = cplx_mul(model_regs[w.src_a], model_regs[w.src_b]);
                    model_acc = r;
                end
                OP_MAC: begin
                    r = cplx_add(model_acc, cplx_mul(model_regs[w.src_a], model_regs[w.src_b]));
                    model_acc = r;
                end
                default: writes = 1'b0;
            endcase
            if (writes) begin
                model_regs[w.dst] = r;
                if (w.emit) begin
                    exp_q.push_back(r);
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // checking and reporting
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time %0t: %s got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_results();
        check_value("dout count", got_q.size(), exp_q.size());
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            check_value($sformatf("dout[%0d]", i), got_q[i], exp_q[i]);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    ////////////////////////////////////////
    // host side stimulus
    ////////////////////////////////////////

    task automatic add_inst(input opcode_e op, input int dst, input int src_a,
                            input int src_b, input bit emit);
        inst_t w;
        w.op    = op;
        w.dst   = reg_addr_t'(dst);
        w.src_a = reg_addr_t'(src_a);
        w.src_b = reg_addr_t'(src_b);
        w.emit  = emit;
        prog_q.push_back(w);
    endtask

    task automatic fill_random_data();
        foreach (data_init[i]) begin
            data_init[i] = cplx_t'($urandom());
        end
    endtask

    // program words go in from address 0
    task automatic load_program();
        foreach (prog_q[i]) begin
            @(negedge clk);
            inst_v = 1'b1;
            inst   = prog_q[i];
        end
        @(negedge clk);
        inst_v = 1'b0;
    endtask

    // all 16 words so the load counter wraps back to 0
    task automatic load_data();
        foreach (data_init[i]) begin
            @(negedge clk);
            din_v = 1'b1;
            din   = data_init[i];
        end
        @(negedge clk);
        din_v = 1'b0;
        model_regs = data_init;
    endtask

    // four-phase run that collects dout until ack
    task automatic run_program(input bit junk_load);
        bit acked;
        acked = 1'b0;
        got_q.delete();
        @(negedge clk);
        run_req = 1'b1;
        for (int cycles = 0; cycles < RUN_LIMIT && !acked; cycles++) begin
            @(negedge clk);
            if (dout_v) begin
                got_q.push_back(dout);
            end
            if (run_ack) begin
                acked = 1'b1;
                din_v = 1'b0;
            end else if (junk_load) begin
                // must be ignored while running
                din_v = 1'b1;
                din   = cplx_t'($urandom());
            end
        end
        run_req = 1'b0;
        if (!acked) begin
            $display("run_ack did not rise within %0d cycles", RUN_LIMIT);
            errors++;
        end else begin
            // ack drops one cycle after req
            @(negedge clk);
            check_value("run_ack", 32'(run_ack), 32'd0);
        end
    endtask

    task automatic execute_program(input bit junk_load);
        load_program();
        model_program();
        run_program(junk_load);
        compare_results();
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_handshake();
        int e0;
        e0 = errors;
        check_value("run_ack", 32'(run_ack), 32'd0);
        check_value("dout_v", 32'(dout_v), 32'd0);
        fill_random_data();
        load_data();
        prog_q.delete();
        add_inst(OP_HALT, 0, 0, 0, 1'b0);
        execute_program(1'b0);
        // second run reloads the program at address 0
        prog_q.delete();
        add_inst(OP_ADD, 2, 0, 1, 1'b1);
        add_inst(OP_HALT, 0, 0, 0, 1'b0);
        execute_program(1'b0);
        report_test("handshake", e0);
    endtask

    task automatic test_add_sub();
        int e0;
        e0 = errors;
        fill_random_data();
        // extremes so that sums and differences wrap
        data_init[0] = make_cplx(32767, -32768);
        data_init[1] = make_cplx(1, -1);
        data_init[2] = make_cplx(-32768, 32767);
        load_data();
        prog_q.delete();
        add_inst(OP_ADD, 8, 0, 1, 1'b1);
        add_inst(OP_SUB, 9, 0, 1, 1'b1);
        add_inst(OP_SUB, 10, 2, 1, 1'b1);
        add_inst(OP_ADD, 11, 0, 0, 1'b1);
        add_inst(OP_SUB, 12, 1, 2, 1'b1);
        add_inst(OP_ADD, 13, 4, 5, 1'b1);
        add_inst(OP_SUB, 14, 6, 7, 1'b1);
        add_inst(OP_ADD, 15, 5, 6, 1'b1);
        add_inst(OP_HALT, 0, 0, 0, 1'b0);
        execute_program(1'b0);
        report_test("add_sub", e0);
    endtask

    task automatic test_multiply();
        int e0;
        e0 = errors;
        fill_random_data();
        // about +-0.99 and -1 in q1.15
        data_init[0] = make_cplx(32440, 32440);
        data_init[1] = make_cplx(-32440, 32440);
        data_init[2] = make_cplx(-32768, -32768);
        data_init[3] = make_cplx(32767, -32768);
        data_init[4] = make_cplx(-16384, 8192);
        load_data();
        prog_q.delete();
        add_inst(OP_MUL, 8, 0, 1, 1'b1);
        add_inst(OP_MUL, 9, 1, 1, 1'b1);
        // -1 squared overflows the im term before truncation
        add_inst(OP_MUL, 10, 2, 2, 1'b1);
        add_inst(OP_MUL, 11, 3, 2, 1'b1);
        add_inst(OP_MUL, 12, 4, 0, 1'b1);
        add_inst(OP_MUL, 13, 5, 6, 1'b1);
        add_inst(OP_MUL, 14, 7, 3, 1'b1);
        add_inst(OP_HALT, 0, 0, 0, 1'b0);
        execute_program(1'b0);
        report_test("multiply", e0);
    endtask

    task automatic test_accumulate();
        int e0;
        e0 = errors;
        fill_random_data();
        load_data();
        prog_q.delete();
        add_inst(OP_MUL, 8, 0, 1, 1'b1);
        add_inst(OP_MAC, 9, 2, 3, 1'b1);
        add_inst(OP_MAC, 10, 4, 5, 1'b1);
        add_inst(OP_MAC, 11, 6, 7, 1'b1);
        // restart
        add_inst(OP_MUL, 12, 1, 2, 1'b1);
        add_inst(OP_MAC, 13, 3, 4, 1'b1);
        add_inst(OP_HALT, 0, 0, 0, 1'b0);
        execute_program(1'b0);
        report_test("accumulate", e0);
    endtask

    task automatic test_dependency();
        int e0;
        e0 = errors;
        fill_random_data();
        load_data();
        prog_q.delete();
        // each one reads the previous destination
        add_inst(OP_ADD, 2, 0, 1, 1'b1);
        add_inst(OP_SUB, 3, 2, 0, 1'b1);
        add_inst(OP_MUL, 4, 3, 2, 1'b1);
        add_inst(OP_MAC, 5, 4, 3, 1'b1);
        add_inst(OP_ADD, 4, 5, 4, 1'b1);
        add_inst(OP_SUB, 6, 4, 5, 1'b1);
        add_inst(OP_MUL, 6, 6, 5, 1'b1);
        add_inst(OP_HALT, 0, 0, 0, 1'b0);
        execute_program(1'b0);
        report_test("dependency", e0);
    endtask

    task automatic test_silent_writeback();
        int e0;
        e0 = errors;
        fill_random_data();
        // zero register for read-out adds
        data_init[15] = '0;
        load_data();
        prog_q.delete();
        add_inst(OP_SUB, 8, 0, 1, 1'b0);
        add_inst(OP_MUL, 9, 2, 3, 1'b0);
        add_inst(OP_ADD, 10, 8, 9, 1'b0);
        add_inst(OP_ADD, 11, 8, 15, 1'b1);
        add_inst(OP_ADD, 12, 9, 15, 1'b1);
        add_inst(OP_ADD, 13, 10, 15, 1'b1);
        add_inst(OP_HALT, 0, 0, 0, 1'b0);
        execute_program(1'b1);
        // loaded words must survive the junk loads
        prog_q.delete();
        add_inst(OP_ADD, 14, 0, 15, 1'b1);
        add_inst(OP_ADD, 14, 1, 15, 1'b1);
        add_inst(OP_ADD, 14, 2, 15, 1'b1);
        add_inst(OP_ADD, 14, 3, 15, 1'b1);
        add_inst(OP_HALT, 0, 0, 0, 1'b0);
        execute_program(1'b1);
        report_test("silent_writeback", e0);
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'hf78a_81ca));
        rst_n        = 1'b0;
        inst_v       = 1'b0;
        inst         = '0;
        din_v        = 1'b0;
        din          = '0;
        run_req      = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        model_acc    = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        test_handshake();
        test_add_sub();
        test_multiply();
        test_accumulate();
        test_dependency();
        test_silent_writeback();
        $display("tests run %0d, failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("timeout, tests did not complete within %0d ns",
                 NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run the PE testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f compile.f \
    --top-module pe_tb \
    -o pe_sim

./obj_dir/pe_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
exit 0

/* source/cplx_pkg.sv */
package cplx_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    // one real or imaginary component
    localparam int DATA_WIDTH = 16;

    // q1.15, products scaled back by this
    localparam int FRAC_BITS = 15;

    // full width of one partial product
    localparam int PROD_WIDTH = 2 * DATA_WIDTH;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    typedef logic signed [DATA_WIDTH-1:0] sample_t;

    // signed x signed, no loss
    typedef logic signed [PROD_WIDTH-1:0] prod_t;

    // sum or difference of two products, one guard bit
    typedef logic signed [PROD_WIDTH:0] psum_t;

    // one complex word, re in the upper half
    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

endpackage

/* source/pe_complex_alu.sv */
`timescale 1ns/1ps

module pe_complex_alu
    import cplx_pkg::*;
    import pe_isa_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       op_v,
    input  exec_ctrl_t op_ctrl,
    input  cplx_t      a,
    input  cplx_t      b,
    output logic       res_v,
    output exec_ctrl_t res_ctrl,
    output cplx_t      res
);

    // stage 1 registers
    logic       s1_v;
    exec_ctrl_t s1_ctrl;
    prod_t      p_rr, p_ii, p_ri, p_ir;
    cplx_t      s1_sum;
    cplx_t      s1_diff;

    // stage 2 combinational
    psum_t re_full, im_full;
    cplx_t mul_c;
    cplx_t mac_c;
    cplx_t acc;

    ////////////////////////////////////////
    // stage 1, products and add/sub
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        s1_ctrl     <= op_ctrl;
        p_rr        <= a.re * b.re;
        p_ii        <= a.im * b.im;
        p_ri        <= a.re * b.im;
        p_ir        <= a.im * b.re;
        // 16 bit context, wraps
        s1_sum.re   <= a.re + b.re;
        s1_sum.im   <= a.im + b.im;
        s1_diff.re  <= a.re - b.re;
        s1_diff.im  <= a.im - b.im;
    end

    ////////////////////////////////////////
    // stage 2, scale, combine, select
    ////////////////////////////////////////

    always_comb begin
        // guard bit keeps -1 * -1 terms exact
        re_full  = p_rr - p_ii;
        im_full  = p_ri + p_ir;
        // arithmetic shift, then keep the low 16 bits
        mul_c.re = sample_t'(re_full >>> FRAC_BITS);
        mul_c.im = sample_t'(im_full >>> FRAC_BITS);
        mac_c.re = acc.re + mul_c.re;
        mac_c.im = acc.im + mul_c.im;
    end

    always_ff @(posedge clk) begin
        res_ctrl <= s1_ctrl;
        case (s1_ctrl.op)
            OP_ADD:  res <= s1_sum;
            OP_SUB:  res <= s1_diff;
            OP_MUL:  res <= mul_c;
            OP_MAC:  res <= mac_c;
            default: res <= '0;
        endcase
    end

    // valids and accumulator
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_v  <= 1'b0;
            res_v <= 1'b0;
            acc   <= '0;
        end else begin
            s1_v  <= op_v;
            res_v <= s1_v;
            // mul restarts, mac accumulates
            if (s1_v && s1_ctrl.op == OP_MUL) begin
                acc <= mul_c;
            end else if (s1_v && s1_ctrl.op == OP_MAC) begin
                acc <= mac_c;
            end
        end
    end

endmodule

/* source/pe_data_mem.sv */
`timescale 1ns/1ps

module pe_data_mem
    import cplx_pkg::*;
    import pe_isa_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       din_v,
    input  cplx_t      din,
    input  logic       run_active,
    input  reg_addr_t  rd_addr_a,
    input  reg_addr_t  rd_addr_b,
    input  logic       ctrl_v,
    input  exec_ctrl_t ctrl,
    output logic       op_v,
    output exec_ctrl_t op_ctrl,
    output cplx_t      a,
    output cplx_t      b,
    input  logic       wb_v,
    input  reg_addr_t  wb_addr,
    input  cplx_t      wb_data
);

    cplx_t     regs [REG_NUM];
    // next load slot, wraps at REG_NUM
    reg_addr_t ld_addr;
    logic      ld_en;

    // host loads ignored during a run
    assign ld_en = din_v && !run_active;

    ////////////////////////////////////////
    // write ports
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wb_v) begin
            regs[wb_addr] <= wb_data;
        end else if (ld_en) begin
            regs[ld_addr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_addr <= '0;
        end else if (ld_en) begin
            ld_addr <= ld_addr + 1'b1;
        end
    end

    ////////////////////////////////////////
    // read ports
    ////////////////////////////////////////

    // write-first, same cycle wb wins over the array
    always_ff @(posedge clk) begin
        a       <= (wb_v && wb_addr == rd_addr_a) ? wb_data : regs[rd_addr_a];
        b       <= (wb_v && wb_addr == rd_addr_b) ? wb_data : regs[rd_addr_b];
        op_ctrl <= ctrl;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_v <= 1'b0;
        end else begin
            op_v <= ctrl_v;
        end
    end

endmodule

/* source/pe_decode.sv */
`timescale 1ns/1ps

module pe_decode import pe_isa_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       issue_v,
    input  inst_t      issue_inst,
    output logic       stall,
    output reg_addr_t  rd_addr_a,
    output reg_addr_t  rd_addr_b,
    output logic       ctrl_v,
    output exec_ctrl_t ctrl,
    input  logic       retire_v,
    input  reg_addr_t  retire_addr
);

    // one pending bit per data word
    logic [REG_NUM-1:0] pending;
    // destinations of mul/mac still in flight
    logic [REG_NUM-1:0] acc_pend;
    logic [REG_NUM-1:0] retire_mask;
    logic [REG_NUM-1:0] set_mask;
    logic [REG_NUM-1:0] busy;
    logic               writes;
    logic               hazard;
    logic               accept;

    ////////////////////////////////////////
    // hazard check
    ////////////////////////////////////////

    always_comb begin
        retire_mask = '0;
        if (retire_v) begin
            retire_mask[retire_addr] = 1'b1;
        end
        // a retiring word is free this cycle
        busy   = pending & ~retire_mask;
        writes = issue_inst.op inside {OP_ADD, OP_SUB, OP_MUL, OP_MAC};
        // raw on either source, waw on dst
        hazard = busy[issue_inst.src_a] | busy[issue_inst.src_b] | busy[issue_inst.dst];
        // mac waits for every older accumulator op
        if (issue_inst.op == OP_MAC && |(acc_pend & ~retire_mask)) begin
            hazard = 1'b1;
        end
        stall  = issue_v && writes && hazard;
        accept = issue_v && !stall;
        set_mask = '0;
        if (accept && writes) begin
            set_mask[issue_inst.dst] = 1'b1;
        end
    end

    ////////////////////////////////////////
    // scoreboard and control register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending  <= '0;
            acc_pend <= '0;
            ctrl_v   <= 1'b0;
        end else begin
            pending <= (pending & ~retire_mask) | set_mask;
            if (issue_inst.op inside {OP_MUL, OP_MAC}) begin
                acc_pend <= (acc_pend & ~retire_mask) | set_mask;
            end else begin
                acc_pend <= acc_pend & ~retire_mask;
            end
            ctrl_v <= accept;
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        rd_addr_a <= issue_inst.src_a;
        rd_addr_b <= issue_inst.src_b;
        ctrl.op   <= issue_inst.op;
        ctrl.dst  <= issue_inst.dst;
        ctrl.emit <= issue_inst.emit;
    end

endmodule

/* source/pe_fetch.sv */
`timescale 1ns/1ps

module pe_fetch import pe_isa_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  inst_v,
    input  inst_t inst,
    input  logic  run_req,
    output logic  run_ack,
    output logic  run_active,
    input  logic  stall,
    input  logic  empty,
    output logic  issue_v,
    output inst_t issue_inst
);

    inst_t        imem [IMEM_DEPTH];
    pc_t          load_addr;
    pc_t          pc;
    fetch_state_e state;
    inst_t        fetch_inst;

    // async read of the small program array
    assign fetch_inst = imem[pc];
    // loads are only taken while idle
    assign run_active = (state != IDLE);

    ////////////////////////////////////////
    // program load and issue register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == IDLE && inst_v) begin
            imem[load_addr] <= inst;
        end
        // held while decode stalls
        if (state == RUN && !stall) begin
            issue_inst <= fetch_inst;
        end
    end

    ////////////////////////////////////////
    // run fsm
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            pc        <= '0;
            load_addr <= '0;
            issue_v   <= 1'b0;
            run_ack   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (inst_v) begin
                        load_addr <= load_addr + 1'b1;
                    end
                    // four-phase, req rises only while ack is low
                    if (run_req && !run_ack) begin
                        state <= RUN;
                        pc    <= '0;
                    end
                end
                RUN: begin
                    if (!stall) begin
                        // halt stops fetch, never issued
                        if (fetch_inst.op == OP_HALT) begin
                            issue_v <= 1'b0;
                            state   <= DRAIN;
                        end else begin
                            issue_v <= 1'b1;
                            pc      <= pc + 1'b1;
                        end
                    end
                end
                DRAIN: begin
                    if (empty) begin
                        state   <= DONE;
                        run_ack <= 1'b1;
                    end
                end
                default: begin
                    // done, ack held until host drops req
                    if (!run_req) begin
                        state     <= IDLE;
                        run_ack   <= 1'b0;
                        load_addr <= '0;
                    end
                end
            endcase
        end
    end

endmodule

/* source/pe_isa_pkg.sv */
package pe_isa_pkg;

    ////////////////////////////////////////
    // storage sizes
    ////////////////////////////////////////

    // complex data words
    localparam int REG_NUM = 16;
    // instruction words
    localparam int IMEM_DEPTH = 32;

    localparam int REG_ADDR_WIDTH = $clog2(REG_NUM);
    localparam int PC_WIDTH       = $clog2(IMEM_DEPTH);

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [PC_WIDTH-1:0]       pc_t;

    ////////////////////////////////////////
    // instruction format
    ////////////////////////////////////////

    // halt sits apart from the alu codes
    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_MUL  = 3'd3,
        OP_MAC  = 3'd4,
        OP_HALT = 3'd7
    } opcode_e;

    // 3 + 4 + 4 + 4 + 1 = 16 bits
    typedef struct packed {
        opcode_e   op;
        reg_addr_t dst;
        reg_addr_t src_a;
        reg_addr_t src_b;
        logic      emit;
    } inst_t;

    // what the execute and result stages still need
    typedef struct packed {
        opcode_e   op;
        reg_addr_t dst;
        logic      emit;
    } exec_ctrl_t;

    // run control
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        DONE
    } fetch_state_e;

endpackage

/* source/pe_result.sv */
`timescale 1ns/1ps

module pe_result
    import cplx_pkg::*;
    import pe_isa_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       res_v,
    input  exec_ctrl_t res_ctrl,
    input  cplx_t      res,
    input  logic       pipe_busy,
    output logic       wb_v,
    output reg_addr_t  wb_addr,
    output cplx_t      wb_data,
    output logic       retire_v,
    output reg_addr_t  retire_addr,
    output logic       dout_v,
    output cplx_t      dout,
    output logic       empty
);

    logic  writes;
    // covers the alu stage 1 slot, one behind data mem
    logic  busy_q;
    cplx_t res_q;

    // nop flows through but never writes
    assign writes = res_v && res_ctrl.op != OP_NOP;

    // retire a cycle early, data mem bypasses the write
    assign retire_v    = writes;
    assign retire_addr = res_ctrl.dst;

    assign wb_data = res_q;
    assign dout    = res_q;

    always_ff @(posedge clk) begin
        res_q   <= res;
        wb_addr <= res_ctrl.dst;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_v   <= 1'b0;
            dout_v <= 1'b0;
            busy_q <= 1'b0;
        end else begin
            wb_v   <= writes;
            dout_v <= writes && res_ctrl.emit;
            busy_q <= pipe_busy;
        end
    end

    // nothing left anywhere from decode to output
    assign empty = !(pipe_busy || busy_q || res_v || wb_v || dout_v);

endmodule

/* source/pe_top.sv */
`timescale 1ns/1ps

module pe_top
    import cplx_pkg::*;
    import pe_isa_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  inst_v,
    input  inst_t inst,
    input  logic  din_v,
    input  cplx_t din,
    input  logic  run_req,
    output logic  run_ack,
    output logic  dout_v,
    output cplx_t dout
);

    ////////////////////////////////////////
    // internal links
    ////////////////////////////////////////

    logic       run_active;
    logic       issue_v;
    inst_t      issue_inst;
    logic       stall;
    logic       empty;
    reg_addr_t  rd_addr_a, rd_addr_b;
    logic       ctrl_v;
    exec_ctrl_t ctrl;
    logic       op_v;
    exec_ctrl_t op_ctrl;
    cplx_t      op_a, op_b;
    logic       res_v;
    exec_ctrl_t res_ctrl;
    cplx_t      res;
    logic       wb_v;
    reg_addr_t  wb_addr;
    cplx_t      wb_data;
    logic       retire_v;
    reg_addr_t  retire_addr;
    logic       pipe_busy;

    // decode and operand stages still hold work
    assign pipe_busy = ctrl_v | op_v;

    pe_fetch u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_v     (inst_v),
        .inst       (inst),
        .run_req    (run_req),
        .run_ack    (run_ack),
        .run_active (run_active),
        .stall      (stall),
        .empty      (empty),
        .issue_v    (issue_v),
        .issue_inst (issue_inst)
    );

    pe_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_v     (issue_v),
        .issue_inst  (issue_inst),
        .stall       (stall),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .ctrl_v      (ctrl_v),
        .ctrl        (ctrl),
        .retire_v    (retire_v),
        .retire_addr (retire_addr)
    );

    pe_data_mem u_data_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .din_v      (din_v),
        .din        (din),
        .run_active (run_active),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .ctrl_v     (ctrl_v),
        .ctrl       (ctrl),
        .op_v       (op_v),
        .op_ctrl    (op_ctrl),
        .a          (op_a),
        .b          (op_b),
        .wb_v       (wb_v),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    pe_complex_alu u_alu (
        .clk      (clk),
        .rst_n    (rst_n),
        .op_v     (op_v),
        .op_ctrl  (op_ctrl),
        .a        (op_a),
        .b        (op_b),
        .res_v    (res_v),
        .res_ctrl (res_ctrl),
        .res      (res)
    );

    pe_result u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .res_v       (res_v),
        .res_ctrl    (res_ctrl),
        .res         (res),
        .pipe_busy   (pipe_busy),
        .wb_v        (wb_v),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .retire_v    (retire_v),
        .retire_addr (retire_addr),
        .dout_v      (dout_v),
        .dout        (dout),
        .empty       (empty)
    );

endmodule
